//--- Bender.yml
package:
  name: pong_renderer

sources:
  - files:
      - design/pong_pkg.sv
      - design/frame_timer.sv
      - design/draw_sequencer.sv
      - design/object_store.sv
      - design/box_rasterizer.sv
      - design/pong_renderer.sv
  - target: test
    files:
      - verification/pong_renderer_checker.sv
      - verification/pong_renderer_tb.sv

//--- design/box_rasterizer.sv
`default_nettype none

module box_rasterizer import pong_pkg::*; (
	input  logic   clk,
	input  logic   resetn,
	input  logic   busy,
	input  box_t   box,
	output logic   done,
	output pixel_t pixel,
	output logic   plot
);

	coord_x_t x_cnt;
	coord_y_t y_cnt;
	logic     last_col;
	logic     last_row;

	assign last_col = (x_cnt == coord_x_t'(box.w - 1'b1));
	assign last_row = (y_cnt == coord_y_t'(box.h - 1'b1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_cnt <= '0;
			y_cnt <= '0;
			done  <= 1'b0;
			plot  <= 1'b0;
			pixel <= '0;
		end else if (!busy) begin
			// start state of a job, ready for a new box
			x_cnt <= '0;
			y_cnt <= '0;
			done  <= 1'b0;
			plot  <= 1'b0;
		end else if (done) begin
			// box finished, wait for the sequencer to move on
			plot <= 1'b0;
		end else begin
			pixel.x      <= box.x + x_cnt;
			pixel.y      <= box.y + y_cnt;
			pixel.colour <= box.colour;
			plot         <= 1'b1;
			if (last_col && last_row) begin
				done <= 1'b1;
			end else if (last_col) begin
				x_cnt <= '0;
				y_cnt <= y_cnt + 1'b1;
			end else begin
				x_cnt <= x_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/draw_sequencer.sv
`default_nettype none

module draw_sequencer import pong_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  logic frame_tick,
	input  logic scored,
	input  logic done,
	output job_t job,
	output logic busy
);

	typedef enum logic [3:0] {
		s_idle,
		s_blank_start,
		s_blank_wait,
		s_erase_left_start,
		s_erase_left_wait,
		s_draw_left_start,
		s_draw_left_wait,
		s_erase_right_start,
		s_erase_right_wait,
		s_draw_right_start,
		s_draw_right_wait,
		s_erase_ball_start,
		s_erase_ball_wait,
		s_draw_ball_start,
		s_draw_ball_wait
	} state_t;

	state_t state;
	state_t next_state;

	always_comb begin
		next_state = state;
		// a score aborts anything except an ongoing blank
		if (scored && state != s_blank_start && state != s_blank_wait) begin
			next_state = s_blank_start;
		end else begin
			case (state)
				s_idle:              if (frame_tick) next_state = s_erase_left_start;
				s_blank_start:       next_state = s_blank_wait;
				s_blank_wait:        if (done) next_state = s_idle;
				s_erase_left_start:  next_state = s_erase_left_wait;
				s_erase_left_wait:   if (done) next_state = s_draw_left_start;
				s_draw_left_start:   next_state = s_draw_left_wait;
				s_draw_left_wait:    if (done) next_state = s_erase_right_start;
				s_erase_right_start: next_state = s_erase_right_wait;
				s_erase_right_wait:  if (done) next_state = s_draw_right_start;
				s_draw_right_start:  next_state = s_draw_right_wait;
				s_draw_right_wait:   if (done) next_state = s_erase_ball_start;
				s_erase_ball_start:  next_state = s_erase_ball_wait;
				s_erase_ball_wait:   if (done) next_state = s_draw_ball_start;
				s_draw_ball_start:   next_state = s_draw_ball_wait;
				s_draw_ball_wait:    if (done) next_state = s_idle;
				default:             next_state = s_blank_start;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= s_blank_start;
		end else begin
			state <= next_state;
		end
	end

	// job follows the state, start and wait share it
	always_comb begin
		case (state)
			s_erase_left_start, s_erase_left_wait:   job = '{kind: erase, obj: paddle_left};
			s_draw_left_start, s_draw_left_wait:     job = '{kind: draw, obj: paddle_left};
			s_erase_right_start, s_erase_right_wait: job = '{kind: erase, obj: paddle_right};
			s_draw_right_start, s_draw_right_wait:   job = '{kind: draw, obj: paddle_right};
			s_erase_ball_start, s_erase_ball_wait:   job = '{kind: erase, obj: ball};
			s_draw_ball_start, s_draw_ball_wait:     job = '{kind: draw, obj: ball};
			default:                                 job = '{kind: blank, obj: screen};
		endcase
	end

	assign busy = (state == s_blank_wait) || (state == s_erase_left_wait) ||
		(state == s_draw_left_wait) || (state == s_erase_right_wait) ||
		(state == s_draw_right_wait) || (state == s_erase_ball_wait) ||
		(state == s_draw_ball_wait);

endmodule

`default_nettype wire

//--- design/frame_timer.sv
`default_nettype none

module frame_timer #(
	parameter int CLOCKS_PER_FRAME = 833333
) (
	input  logic clk,
	input  logic resetn,
	output logic frame_tick
);

	localparam int cnt_w = $clog2(CLOCKS_PER_FRAME);

	logic [cnt_w-1:0] count;

	// down-counter, one tick per wrap
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count      <= cnt_w'(CLOCKS_PER_FRAME - 1);
			frame_tick <= 1'b0;
		end else if (count == '0) begin
			count      <= cnt_w'(CLOCKS_PER_FRAME - 1);
			frame_tick <= 1'b1;
		end else begin
			count      <= count - 1'b1;
			frame_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/object_store.sv
`default_nettype none

module object_store import pong_pkg::*; #(
	parameter int SCREEN_W      = 320,
	parameter int SCREEN_H      = 240,
	parameter int PADDLE_W      = 5,
	parameter int PADDLE_H      = 40,
	parameter int BALL_SIZE     = 4,
	parameter int PADDLE_MARGIN = 2
) (
	input  logic        clk,
	input  logic        resetn,
	input  logic        frame_tick,
	input  game_state_t game_state,
	input  colour_t     ball_colour,
	input  job_t        job,
	output box_t        box
);

	localparam coord_x_t left_x   = coord_x_t'(PADDLE_MARGIN);
	localparam coord_x_t right_x  = coord_x_t'(SCREEN_W - PADDLE_W - PADDLE_MARGIN);
	localparam coord_x_t paddle_w = coord_x_t'(PADDLE_W);
	localparam coord_y_t paddle_h = coord_y_t'(PADDLE_H);
	localparam coord_x_t ball_w   = coord_x_t'(BALL_SIZE);
	localparam coord_y_t ball_h   = coord_y_t'(BALL_SIZE);

	game_state_t cur_pos;
	game_state_t prev_pos;
	colour_t     ball_colour_q;
	game_state_t pos;
	logic        is_draw;

	// positions move only on a frame tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cur_pos  <= '0;
			prev_pos <= '0;
		end else if (frame_tick) begin
			prev_pos <= cur_pos;
			cur_pos  <= game_state;
		end
	end

	always_ff @(posedge clk) begin
		if (frame_tick) begin
			ball_colour_q <= ball_colour;
		end
	end

	// erase works on where things were
	assign is_draw = (job.kind == draw);
	assign pos     = is_draw ? cur_pos : prev_pos;

	always_comb begin
		case (job.obj)
			paddle_left:  box = '{x: left_x, y: pos.left_y, w: paddle_w, h: paddle_h,
				colour: is_draw ? colour_paddle : colour_black};
			paddle_right: box = '{x: right_x, y: pos.right_y, w: paddle_w, h: paddle_h,
				colour: is_draw ? colour_paddle : colour_black};
			ball:         box = '{x: pos.ball_x, y: pos.ball_y, w: ball_w, h: ball_h,
				colour: is_draw ? ball_colour_q : colour_black};
			default:      box = '{x: '0, y: '0, w: coord_x_t'(SCREEN_W),
				h: coord_y_t'(SCREEN_H), colour: colour_black};
		endcase
	end

endmodule

`default_nettype wire

//--- design/pong_pkg.sv
`default_nettype none

package pong_pkg;

	// screen coordinates
	typedef logic [9:0] coord_x_t;
	typedef logic [8:0] coord_y_t;

	// 3-bit palette colour
	typedef logic [2:0] colour_t;

	// object a job works on
	typedef enum logic [1:0] {
		paddle_left,
		paddle_right,
		ball,
		screen
	} object_t;

	typedef enum logic [1:0] {
		erase,
		draw,
		blank
	} job_kind_t;

	typedef struct packed {
		job_kind_t kind;
		object_t   obj;
	} job_t;

	// rectangle to rasterize, origin at top left
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		coord_x_t w;
		coord_y_t h;
		colour_t  colour;
	} box_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_t;

	// positions sampled once per frame
	typedef struct packed {
		coord_y_t left_y;
		coord_y_t right_y;
		coord_x_t ball_x;
		coord_y_t ball_y;
	} game_state_t;

	localparam colour_t colour_black  = 3'd0;
	localparam colour_t colour_paddle = 3'd7;

endpackage

`default_nettype wire

//--- design/pong_renderer.sv
`default_nettype none

module pong_renderer import pong_pkg::*; #(
	parameter int SCREEN_W         = 320,
	parameter int SCREEN_H         = 240,
	parameter int PADDLE_W         = 5,
	parameter int PADDLE_H         = 40,
	parameter int BALL_SIZE        = 4,
	parameter int PADDLE_MARGIN    = 2,
	parameter int CLOCKS_PER_FRAME = 833333
) (
	input  logic        clk,
	input  logic        resetn,
	input  logic        scored,
	input  game_state_t game_state,
	input  colour_t     ball_colour,
	output pixel_t      pixel,
	output logic        plot
);

	logic frame_tick;
	job_t job;
	logic busy;
	logic done;
	box_t box;

	frame_timer #(
		.CLOCKS_PER_FRAME(CLOCKS_PER_FRAME)
	) timer0 (
		.clk       (clk),
		.resetn    (resetn),
		.frame_tick(frame_tick)
	);

	draw_sequencer seq0 (
		.clk       (clk),
		.resetn    (resetn),
		.frame_tick(frame_tick),
		.scored    (scored),
		.done      (done),
		.job       (job),
		.busy      (busy)
	);

	object_store #(
		.SCREEN_W     (SCREEN_W),
		.SCREEN_H     (SCREEN_H),
		.PADDLE_W     (PADDLE_W),
		.PADDLE_H     (PADDLE_H),
		.BALL_SIZE    (BALL_SIZE),
		.PADDLE_MARGIN(PADDLE_MARGIN)
	) store0 (
		.clk        (clk),
		.resetn     (resetn),
		.frame_tick (frame_tick),
		.game_state (game_state),
		.ball_colour(ball_colour),
		.job        (job),
		.box        (box)
	);

	box_rasterizer raster0 (
		.clk   (clk),
		.resetn(resetn),
		.busy  (busy),
		.box   (box),
		.done  (done),
		.pixel (pixel),
		.plot  (plot)
	);

endmodule

`default_nettype wire

//--- pong_renderer.f
design/pong_pkg.sv
design/frame_timer.sv
design/draw_sequencer.sv
design/object_store.sv
design/box_rasterizer.sv
design/pong_renderer.sv
verification/pong_renderer_checker.sv
verification/pong_renderer_tb.sv

//--- verification/pong_renderer_checker.sv
`default_nettype none

module pong_renderer_checker import pong_pkg::*; #(
	parameter int SCREEN_W         = 320,
	parameter int SCREEN_H         = 240,
	parameter int PADDLE_W         = 5,
	parameter int PADDLE_H         = 40,
	parameter int BALL_SIZE        = 4,
	parameter int PADDLE_MARGIN    = 2,
	parameter int CLOCKS_PER_FRAME = 833333
) (
	input  logic        clk,
	input  logic        resetn,
	input  game_state_t game_state,
	input  colour_t     ball_colour,
	input  logic        scored,
	input  pixel_t      pixel,
	input  logic        plot,
	output logic        frame_end,
	output logic        blank_end,
	output int          pixel_count,
	output int          mismatch_count,
	output int          fail_count
);

	timeunit 1ns;
	timeprecision 1ps;

	pixel_t      expect_q[$];
	game_state_t cur_pos;
	game_state_t prev_pos;
	colour_t     colour_q;
	logic        blank_active;
	int          abort_cnt;
	int          cycle;

	// row-major walk from the origin
	task automatic push_box(input int x, input int y, input int w, input int h,
		input colour_t colour);
		pixel_t p;
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				p.x = coord_x_t'(x + c);
				p.y = coord_y_t'(y + r);
				p.colour = colour;
				expect_q.push_back(p);
			end
		end
	endtask

	task automatic load_blank();
		expect_q.delete();
		push_box(0, 0, SCREEN_W, SCREEN_H, colour_black);
		blank_active = 1'b1;
	endtask

	// erase at the old place and draw at the new one
	task automatic load_frame();
		int right_x;
		right_x = SCREEN_W - PADDLE_W - PADDLE_MARGIN;
		push_box(PADDLE_MARGIN, prev_pos.left_y, PADDLE_W, PADDLE_H, colour_black);
		push_box(PADDLE_MARGIN, cur_pos.left_y, PADDLE_W, PADDLE_H, colour_paddle);
		push_box(right_x, prev_pos.right_y, PADDLE_W, PADDLE_H, colour_black);
		push_box(right_x, cur_pos.right_y, PADDLE_W, PADDLE_H, colour_paddle);
		push_box(prev_pos.ball_x, prev_pos.ball_y, BALL_SIZE, BALL_SIZE, colour_black);
		push_box(cur_pos.ball_x, cur_pos.ball_y, BALL_SIZE, BALL_SIZE, colour_q);
	endtask

	always @(posedge clk) begin : compare
		pixel_t want;
		frame_end <= 1'b0;
		blank_end <= 1'b0;
		if (!resetn) begin
			cur_pos = '0;
			prev_pos = '0;
			colour_q = colour_black;
			abort_cnt = 0;
			cycle = 0;
			pixel_count <= 0;
			mismatch_count <= 0;
			fail_count <= 0;
			load_blank();
		end else begin
			cycle++;
			// the old frame may still put out a pixel right after a score
			if (abort_cnt != 0) begin
				abort_cnt--;
				if (abort_cnt == 0) begin
					load_blank();
				end
			end
			// positions shift on every tick but a frame starts only from idle
			if (cycle > 1 && (cycle - 1) % CLOCKS_PER_FRAME == 0) begin
				prev_pos = cur_pos;
				cur_pos = game_state;
				colour_q = ball_colour;
				if (expect_q.size() == 0 && abort_cnt == 0) begin
					load_frame();
				end
			end
			if (scored && !blank_active && abort_cnt == 0) begin
				abort_cnt = 2;
			end
			if (plot) begin
				pixel_count <= pixel_count + 1;
				if (expect_q.size() == 0) begin
					$display("pixel plotted at x=%0d y=%0d while nothing was left to draw",
						pixel.x, pixel.y);
					fail_count <= fail_count + 1;
				end else begin
					want = expect_q.pop_front();
					if (pixel !== want) begin
						$display("mismatch pixel x/y/colour got %h/%h/%h expected %h/%h/%h",
							pixel.x, pixel.y, pixel.colour, want.x, want.y, want.colour);
						mismatch_count <= mismatch_count + 1;
					end
					if (expect_q.size() == 0 && blank_active) begin
						blank_active = 1'b0;
						blank_end <= 1'b1;
					end else if (expect_q.size() == 0) begin
						frame_end <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/pong_renderer_tb.sv
`default_nettype none

module pong_renderer_tb import pong_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int screen_w     = 64;
	localparam int screen_h     = 48;
	localparam int paddle_w     = 3;
	localparam int paddle_h     = 10;
	localparam int ball_size    = 4;
	localparam int margin       = 2;
	localparam int frame_clocks = 6000;
	localparam int frames       = 16;
	localparam int blank_limit  = 2 * screen_w * screen_h;

	// what a wait loop looks for
	localparam int ev_plot      = 0;
	localparam int ev_frame_end = 1;
	localparam int ev_blank_end = 2;

	logic        clk;
	logic        resetn;
	logic        scored;
	game_state_t game_state;
	colour_t     ball_colour;
	pixel_t      pixel;
	logic        plot;
	logic        frame_end;
	logic        blank_end;
	int          pixel_count;
	int          mismatch_count;
	int          fail_count;
	int          timeout_count;
	logic [31:0] lfsr;
	logic        ok;
	logic        score_now;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// new positions, always fully on screen
	task automatic new_game_state();
		game_state_t gs;
		gs.left_y   = coord_y_t'(take_bits(9) % (screen_h - paddle_h + 1));
		gs.right_y  = coord_y_t'(take_bits(9) % (screen_h - paddle_h + 1));
		gs.ball_x   = coord_x_t'(take_bits(10) % (screen_w - ball_size + 1));
		gs.ball_y   = coord_y_t'(take_bits(9) % (screen_h - ball_size + 1));
		game_state  <= gs;
		ball_colour <= colour_t'(take_bits(3));
	endtask

	task automatic wait_for_event(input int which, input int limit, input string what,
		output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(posedge clk);
			case (which)
				ev_plot:      seen = plot;
				ev_frame_end: seen = frame_end;
				default:      seen = blank_end;
			endcase
			n++;
		end
		if (!seen) begin
			$display("timeout: no sign of %s within %0d cycles", what, limit);
			timeout_count++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	pong_renderer #(
		.SCREEN_W        (screen_w),
		.SCREEN_H        (screen_h),
		.PADDLE_W        (paddle_w),
		.PADDLE_H        (paddle_h),
		.BALL_SIZE       (ball_size),
		.PADDLE_MARGIN   (margin),
		.CLOCKS_PER_FRAME(frame_clocks)
	) dut0 (
		.clk        (clk),
		.resetn     (resetn),
		.scored     (scored),
		.game_state (game_state),
		.ball_colour(ball_colour),
		.pixel      (pixel),
		.plot       (plot)
	);

	pong_renderer_checker #(
		.SCREEN_W        (screen_w),
		.SCREEN_H        (screen_h),
		.PADDLE_W        (paddle_w),
		.PADDLE_H        (paddle_h),
		.BALL_SIZE       (ball_size),
		.PADDLE_MARGIN   (margin),
		.CLOCKS_PER_FRAME(frame_clocks)
	) checker0 (
		.clk           (clk),
		.resetn        (resetn),
		.game_state    (game_state),
		.ball_colour   (ball_colour),
		.scored        (scored),
		.pixel         (pixel),
		.plot          (plot),
		.frame_end     (frame_end),
		.blank_end     (blank_end),
		.pixel_count   (pixel_count),
		.mismatch_count(mismatch_count),
		.fail_count    (fail_count)
	);

	initial begin
		lfsr = 32'hcbb3_c8dc;
		resetn = 1'b0;
		scored = 1'b0;
		timeout_count = 0;
		new_game_state();
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		wait_for_event(ev_blank_end, blank_limit, "the end of the reset blank", ok);
		for (int f = 0; f < frames && ok; f++) begin
			// roughly one frame in four gets a score
			score_now = (take_bits(2) == 0);
			wait_for_event(ev_plot, 2 * frame_clocks, "the start of a frame", ok);
			if (ok && score_now) begin
				repeat (take_bits(8)) @(posedge clk);
				scored <= 1'b1;
				@(posedge clk);
				scored <= 1'b0;
				wait_for_event(ev_blank_end, blank_limit, "the blank after a score", ok);
			end else if (ok) begin
				wait_for_event(ev_frame_end, frame_clocks, "the end of a frame", ok);
				// inputs move only once the ball has been drawn
				if (ok) begin
					new_game_state();
				end
			end
		end
		$display("pixels checked %0d, mismatches %0d, other errors %0d, timeouts %0d",
			pixel_count, mismatch_count, fail_count, timeout_count);
		if (mismatch_count == 0 && fail_count == 0 && timeout_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
